// ==== run.sh ====
#!/bin/sh
# build and run the SSM block testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ssm_block -f src.f -o sim_ssm_block
out=$(./obj_dir/sim_ssm_block)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TEST OK"

// ==== src.f ====
src/ssm_pkg.sv
src/ssm_stage_if.sv
src/ssm_discretize.sv
src/ssm_state_update.sv
src/ssm_readout.sv
src/ssm_group_accum.sv
src/ssm_block_top.sv
tests/ssm_block_checker.sv
tests/tb_ssm_block.sv

// ==== src/ssm_block_top.sv ====
// ================================================
// SSM block top
// unpacks the flat tile buses and chains the four
// pipeline stages with valid/ready links
// ================================================
`default_nettype none

module ssm_block_top import ssm_pkg::*; #(
    parameter int P_TILE          = P_TILE_DEF,
    parameter int N_TILE          = N_TILE_DEF,
    parameter int TILES_PER_GROUP = 2
) (
    input  wire                            clk,
    input  wire                            rstn,
    input  wire                            tile_valid_i,
    output wire                            tile_ready_o,
    input  wire [DW-1:0]                   delta_i,
    input  wire [DW-1:0]                   da_i,
    input  wire [DW-1:0]                   d_i,
    input  wire [P_TILE*DW-1:0]            x_i,
    input  wire [N_TILE*DW-1:0]            b_i,
    input  wire [N_TILE*DW-1:0]            c_i,
    input  wire [P_TILE*N_TILE*DW-1:0]     hprev_i,
    output wire [P_TILE*ACC_W-1:0]         y_o,
    output wire                            y_valid_o,
    input  wire                            y_ready_i
);

    data_t [P_TILE-1:0]             x_vec;
    data_t [N_TILE-1:0]             b_vec;
    data_t [N_TILE-1:0]             c_vec;
    data_t [P_TILE-1:0][N_TILE-1:0] hprev_arr;
    acc_t  [P_TILE-1:0]             y_vec;

    // ==============================================
    // bus unpacking
    // ==============================================
    // channel p at bits p*DW upward, lane n of channel p at index p*N_TILE+n
    for (genvar p = 0; p < P_TILE; p++) begin : g_chan
        assign x_vec[p] = x_i[p*DW +: DW];
        assign y_o[p*ACC_W +: ACC_W] = y_vec[p];
        for (genvar n = 0; n < N_TILE; n++) begin : g_lane
            assign hprev_arr[p][n] = hprev_i[(p*N_TILE+n)*DW +: DW];
        end
    end

    for (genvar n = 0; n < N_TILE; n++) begin : g_bc
        assign b_vec[n] = b_i[n*DW +: DW];
        assign c_vec[n] = c_i[n*DW +: DW];
    end

    // ==============================================
    // stage chain
    // ==============================================
    ssm_stage_if #(.payload_t(disc_t))  disc_if  ();
    ssm_stage_if #(.payload_t(state_t)) state_if ();
    ssm_stage_if #(.payload_t(part_t))  part_if  ();

    ssm_discretize #(
        .P_TILE(P_TILE), .N_TILE(N_TILE), .TILES_PER_GROUP(TILES_PER_GROUP)
    ) u_disc (
        .clk(clk), .rstn(rstn),
        .tile_valid_i(tile_valid_i), .tile_ready_o(tile_ready_o),
        .delta_i(delta_i), .da_i(da_i), .d_i(d_i),
        .x_i(x_vec), .b_i(b_vec), .c_i(c_vec), .hprev_i(hprev_arr),
        .out_o(disc_if)
    );

    ssm_state_update #(.P_TILE(P_TILE), .N_TILE(N_TILE)) u_state (
        .clk(clk), .rstn(rstn), .in_i(disc_if), .out_o(state_if)
    );

    ssm_readout #(.P_TILE(P_TILE), .N_TILE(N_TILE)) u_readout (
        .clk(clk), .rstn(rstn), .in_i(state_if), .out_o(part_if)
    );

    ssm_group_accum #(.P_TILE(P_TILE)) u_accum (
        .clk(clk), .rstn(rstn), .in_i(part_if),
        .y_o(y_vec), .y_valid_o(y_valid_o), .y_ready_i(y_ready_i)
    );

endmodule

`default_nettype wire

// ==== src/ssm_discretize.sv ====
// ================================================
// discretize stage
// counts tiles into groups, tags first/last and
// forms dx = delta*x and xD = x*D per channel
// ================================================
`default_nettype none

module ssm_discretize import ssm_pkg::*; #(
    parameter int P_TILE          = P_TILE_DEF,
    parameter int N_TILE          = N_TILE_DEF,
    parameter int TILES_PER_GROUP = 2
) (
    input  wire                              clk,
    input  wire                              rstn,
    input  wire                              tile_valid_i,
    output logic                             tile_ready_o,
    input  data_t                            delta_i,
    input  data_t                            da_i,
    input  data_t                            d_i,
    input  data_t [P_TILE-1:0]               x_i,
    input  data_t [N_TILE-1:0]               b_i,
    input  data_t [N_TILE-1:0]               c_i,
    input  data_t [P_TILE-1:0][N_TILE-1:0]   hprev_i,
    ssm_stage_if.src                         out_o
);

    localparam int CW = $clog2(TILES_PER_GROUP + 1);

    logic [CW-1:0] tile_cnt;
    logic          take;
    logic          grp_last;

    // single register slot: load when empty or being drained
    assign tile_ready_o = !out_o.valid || out_o.ready;
    assign take         = tile_valid_i && tile_ready_o;
    assign grp_last     = (tile_cnt == CW'(TILES_PER_GROUP - 1));

    // ==============================================
    // control: valid and group tile counter
    // ==============================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out_o.valid <= 1'b0;
            tile_cnt    <= '0;
        end else begin
            if (tile_ready_o)
                out_o.valid <= tile_valid_i;
            // wrap after the last tile of the group
            if (take)
                tile_cnt <= grp_last ? '0 : tile_cnt + 1'b1;
        end
    end

    // payload, only written on an accepted tile
    always_ff @(posedge clk) begin
        if (take) begin
            out_o.first      <= (tile_cnt == '0);
            out_o.last       <= grp_last;
            out_o.data.da    <= da_i;
            out_o.data.b     <= b_i;
            out_o.data.c     <= c_i;
            out_o.data.hprev <= hprev_i;
            for (int p = 0; p < P_TILE; p++) begin
                out_o.data.dx[p] <= mul_q(delta_i, x_i[p]);
                // skip term, used only at group end
                out_o.data.xd[p] <= mul_q(x_i[p], d_i);
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/ssm_group_accum.sv ====
// ================================================
// group accumulator
// sums tile partials over a group, adds xD on the
// last tile and holds y until it is taken
// ================================================
`default_nettype none

module ssm_group_accum import ssm_pkg::*; #(
    parameter int P_TILE = P_TILE_DEF
) (
    input  wire                clk,
    input  wire                rstn,
    ssm_stage_if.dst           in_i,
    output acc_t [P_TILE-1:0]  y_o,
    output logic               y_valid_o,
    input  wire                y_ready_i
);

    logic take;
    logic y_taken;
    // running sum of the current group
    acc_t [P_TILE-1:0] run_sum;
    // sum seen by the current tile, zero on a group's first tile
    acc_t [P_TILE-1:0] base_sum;

    // stall only while a finished y is waiting
    assign in_i.ready = !(y_valid_o && !y_ready_i);
    assign take       = in_i.valid && in_i.ready;
    assign y_taken    = y_valid_o && y_ready_i;

    always_comb begin
        for (int p = 0; p < P_TILE; p++)
            base_sum[p] = in_i.first ? '0 : run_sum[p];
    end

    // ==============================================
    // accumulator and output valid
    // ==============================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            run_sum   <= '0;
            y_valid_o <= 1'b0;
        end else begin
            if (take) begin
                // first tile loads, the others add
                for (int p = 0; p < P_TILE; p++)
                    run_sum[p] <= base_sum[p] + in_i.data.part[p];
            end
            // a new y may replace one that leaves this same cycle
            if (take && in_i.last)
                y_valid_o <= 1'b1;
            else if (y_taken)
                y_valid_o <= 1'b0;
        end
    end

    // y register, held stable under back-pressure
    always_ff @(posedge clk) begin
        if (take && in_i.last) begin
            for (int p = 0; p < P_TILE; p++)
                y_o[p] <= base_sum[p] + in_i.data.part[p] + acc_t'(in_i.data.xd[p]);
        end
    end

endmodule

`default_nettype wire

// ==== src/ssm_pkg.sv ====
// ================================================
// ssm package
// sizes, Q-format types, stage payloads and the
// shared fixed-point multiply of the SSM core
// ================================================
`default_nettype none

package ssm_pkg;

    // fixed-point format
    localparam int DW        = 16;
    localparam int FRAC_BITS = 8;
    localparam int ACC_W     = DW + 8;

    // tile sizes baked into the payload structs
    localparam int P_TILE_DEF = 2;
    localparam int N_TILE_DEF = 4;

    typedef logic signed [DW-1:0]    data_t;
    typedef logic signed [ACC_W-1:0] acc_t;

    // discretize -> state update
    typedef struct packed {
        data_t                                   da;
        data_t [P_TILE_DEF-1:0]                  dx;
        data_t [N_TILE_DEF-1:0]                  b;
        data_t [N_TILE_DEF-1:0]                  c;
        data_t [P_TILE_DEF-1:0][N_TILE_DEF-1:0]  hprev;
        data_t [P_TILE_DEF-1:0]                  xd;
    } disc_t;

    // state update -> readout
    typedef struct packed {
        data_t [P_TILE_DEF-1:0][N_TILE_DEF-1:0]  h;
        data_t [N_TILE_DEF-1:0]                  c;
        data_t [P_TILE_DEF-1:0]                  xd;
    } state_t;

    // readout -> group accumulator
    typedef struct packed {
        acc_t  [P_TILE_DEF-1:0]                  part;
        data_t [P_TILE_DEF-1:0]                  xd;
    } part_t;

    // full product, arithmetic shift back to Q format, low DW bits kept
    function automatic data_t mul_q(input data_t a, input data_t b);
        logic signed [2*DW-1:0] prod;
        prod = a * b;
        return data_t'(prod >>> FRAC_BITS);
    endfunction

endpackage

`default_nettype wire

// ==== src/ssm_readout.sv ====
// ================================================
// readout stage
// hC = h_next*C, reduced over the tile's lanes
// ================================================
`default_nettype none

module ssm_readout import ssm_pkg::*; #(
    parameter int P_TILE = P_TILE_DEF,
    parameter int N_TILE = N_TILE_DEF
) (
    input  wire      clk,
    input  wire      rstn,
    ssm_stage_if.dst in_i,
    ssm_stage_if.src out_o
);

    logic take;
    acc_t [P_TILE-1:0] lane_sum;

    assign in_i.ready = !out_o.valid || out_o.ready;
    assign take       = in_i.valid && in_i.ready;

    // n-reduction, each term sign-extended before the add
    always_comb begin
        for (int p = 0; p < P_TILE; p++) begin
            lane_sum[p] = '0;
            for (int n = 0; n < N_TILE; n++) begin
                lane_sum[p] = lane_sum[p]
                            + acc_t'(mul_q(in_i.data.h[p][n], in_i.data.c[n]));
            end
        end
    end

    // ==============================================
    // output register slot
    // ==============================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            out_o.valid <= 1'b0;
        else if (in_i.ready)
            out_o.valid <= in_i.valid;
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_o.first     <= in_i.first;
            out_o.last      <= in_i.last;
            out_o.data.part <= lane_sum;
            out_o.data.xd   <= in_i.data.xd;
        end
    end

endmodule

`default_nettype wire

// ==== src/ssm_stage_if.sv ====
// ================================================
// stage link
// valid/ready handshake between two pipeline stages
// with group tags and a stage payload
// ================================================
`default_nettype none

interface ssm_stage_if #(
    parameter type payload_t = logic
);

    logic     valid;
    logic     ready;
    // group boundary tags, qualified by valid
    logic     first;
    logic     last;
    payload_t data;

    // producer side holds everything stable while stalled
    modport src (output valid, output first, output last, output data, input ready);

    // consumer side only drives ready
    modport dst (input valid, input first, input last, input data, output ready);

endinterface

`default_nettype wire

// ==== src/ssm_state_update.sv ====
// ================================================
// state update stage
// h_next = dA*hprev + dx*B for every channel/lane
// ================================================
`default_nettype none

module ssm_state_update import ssm_pkg::*; #(
    parameter int P_TILE = P_TILE_DEF,
    parameter int N_TILE = N_TILE_DEF
) (
    input  wire      clk,
    input  wire      rstn,
    ssm_stage_if.dst in_i,
    ssm_stage_if.src out_o
);

    logic  take;
    // combinational next state, wraps at DW bits
    data_t [P_TILE-1:0][N_TILE-1:0] h_next;

    assign in_i.ready = !out_o.valid || out_o.ready;
    assign take       = in_i.valid && in_i.ready;

    // dAh + dBx per (p, n)
    always_comb begin
        for (int p = 0; p < P_TILE; p++) begin
            for (int n = 0; n < N_TILE; n++) begin
                h_next[p][n] = mul_q(in_i.data.da, in_i.data.hprev[p][n])
                             + mul_q(in_i.data.dx[p], in_i.data.b[n]);
            end
        end
    end

    // ==============================================
    // output register slot
    // ==============================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            out_o.valid <= 1'b0;
        else if (in_i.ready)
            out_o.valid <= in_i.valid;
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_o.first   <= in_i.first;
            out_o.last    <= in_i.last;
            out_o.data.h  <= h_next;
            // C and xD ride along for later stages
            out_o.data.c  <= in_i.data.c;
            out_o.data.xd <= in_i.data.xd;
        end
    end

endmodule

`default_nettype wire

// ==== tests/ssm_block_checker.sv ====
// ==================================================
// SSM block checker
// reset and output handshake assertions on the
// top-level ports, attached by bind
// ==================================================
`default_nettype none

module ssm_block_checker import ssm_pkg::*; #(
    parameter int P_TILE = P_TILE_DEF
) (
    input wire                    clk,
    input wire                    rstn,
    input wire                    tile_ready_i,
    input wire                    y_valid_i,
    input wire                    y_ready_i,
    input wire [P_TILE*ACC_W-1:0] y_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // no output while held in reset
    a_quiet_in_reset: assert property (@(posedge clk) !rstn |-> !y_valid_i)
        else $error("y_valid_o high while rstn is low");

    // a pending y is never withdrawn
    a_valid_held: assert property (@(posedge clk) disable iff (!rstn)
        y_valid_i && !y_ready_i |=> y_valid_i)
        else $error("y_valid_o dropped before the output was taken");

    // held y keeps its value
    a_data_held: assert property (@(posedge clk) disable iff (!rstn)
        y_valid_i && !y_ready_i |=> $stable(y_i))
        else $error("y_o changed while stalled");

    // empty pipeline accepts right away
    a_ready_after_reset: assert property (@(posedge clk) $rose(rstn) |-> tile_ready_i)
        else $error("tile_ready_o low in the cycle after reset release");

endmodule

`default_nettype wire

// ==== tests/tb_ssm_block.sv ====
// ==================================================
// SSM block testbench
// directed tests against a fixed-point model, y
// checked in order from a queue, cycle watchdog
// ==================================================
`default_nettype none

module tb_ssm_block import ssm_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int P   = P_TILE_DEF;
    localparam int N   = N_TILE_DEF;
    localparam int TPG = 2;
    // 2 + 40 + 2 + 16 + 5 tiles driven over all tests
    localparam int TILES_TOTAL = 65;
    localparam int CYCLE_LIMIT = 40 * TILES_TOTAL + 200;

    logic              clk = 1'b0;
    logic              rstn;
    logic              tile_valid_i;
    logic              y_ready_i;
    logic [DW-1:0]     delta_i;
    logic [DW-1:0]     da_i;
    logic [DW-1:0]     d_i;
    logic [P*DW-1:0]   x_i;
    logic [N*DW-1:0]   b_i;
    logic [N*DW-1:0]   c_i;
    logic [P*N*DW-1:0] hprev_i;
    wire               tile_ready_o;
    wire [P*ACC_W-1:0] y_o;
    wire               y_valid_o;
    acc_t [P-1:0]      y_vec;

    // tile being presented
    data_t cur_delta;
    data_t cur_da;
    data_t cur_d;
    data_t cur_x [P];
    data_t cur_b [N];
    data_t cur_c [N];
    data_t cur_h [P][N];

    // reference model state and expected y queue
    acc_t         model_sum [P];
    int           model_cnt = 0;
    acc_t [P-1:0] exp_q [$];

    integer seed = 32'h423c_024f;
    int     cycle = 0;
    int     accept_cycle = 0;
    int     y_count = 0;
    int     err_cnt = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     stretch [16];
    logic   stall_seen;
    logic   stream_done;

    always #20 clk = ~clk;

    ssm_block_top #(.P_TILE(P), .N_TILE(N), .TILES_PER_GROUP(TPG)) u_dut (
        .clk(clk), .rstn(rstn),
        .tile_valid_i(tile_valid_i), .tile_ready_o(tile_ready_o),
        .delta_i(delta_i), .da_i(da_i), .d_i(d_i),
        .x_i(x_i), .b_i(b_i), .c_i(c_i), .hprev_i(hprev_i),
        .y_o(y_o), .y_valid_o(y_valid_o), .y_ready_i(y_ready_i)
    );

    bind ssm_block_top ssm_block_checker #(.P_TILE(P_TILE)) u_checker (
        .clk(clk), .rstn(rstn), .tile_ready_i(tile_ready_o),
        .y_valid_i(y_valid_o), .y_ready_i(y_ready_i), .y_i(y_o)
    );

    assign y_vec = y_o;

    // ==============================================
    // reference model
    // ==============================================
    // Q8.8 product with a 32-bit intermediate that wraps to 16 bits
    function automatic data_t q_mult(input data_t a, input data_t b);
        int full;
        full = int'(a) * int'(b);
        return data_t'(full >>> FRAC_BITS);
    endfunction

    function automatic data_t rand_data();
        return data_t'($random(seed)) >>> 3;
    endfunction

    task automatic model_tile();
        data_t        dx;
        data_t        xd;
        data_t        h;
        acc_t         part;
        acc_t [P-1:0] y_exp;
        for (int p = 0; p < P; p++) begin
            dx   = q_mult(cur_delta, cur_x[p]);
            xd   = q_mult(cur_x[p], cur_d);
            part = '0;
            for (int n = 0; n < N; n++) begin
                h    = q_mult(cur_da, cur_h[p][n]) + q_mult(dx, cur_b[n]);
                part = part + acc_t'(q_mult(h, cur_c[n]));
            end
            // first tile of a group starts a fresh sum
            model_sum[p] = (model_cnt == 0) ? part : model_sum[p] + part;
            y_exp[p]     = model_sum[p] + acc_t'(xd);
        end
        if (model_cnt == TPG - 1) begin
            exp_q.push_back(y_exp);
            model_cnt = 0;
        end else begin
            model_cnt++;
        end
    endtask

    // ==============================================
    // checks
    // ==============================================
    task automatic compare_y(input acc_t exp_v, input acc_t act_v, input int idx);
        if (act_v !== exp_v) begin
            $display("Mismatch at %0t: y_o[%0d] expected %0d, actual %0d",
                     $time, idx, exp_v, act_v);
            err_cnt++;
        end
    endtask

    task automatic check_count(input string what, input int exp_n, input int act_n);
        if (act_n != exp_n) begin
            $display("%s: expected %0d y outputs but saw %0d", what, exp_n, act_n);
            err_cnt++;
        end
    endtask

    task automatic check_latency(input int exp_n, input int act_n);
        if (act_n != exp_n) begin
            $display("y_valid_o rose %0d cycles after the last tile, expected %0d",
                     act_n, exp_n);
            err_cnt++;
        end
    endtask

    task automatic take_y();
        acc_t [P-1:0] exp_y;
        y_count++;
        if (exp_q.size() == 0) begin
            $display("y_o taken at %0t with no group expected", $time);
            err_cnt++;
        end else begin
            exp_y = exp_q.pop_front();
            for (int p = 0; p < P; p++)
                compare_y(exp_y[p], y_vec[p], p);
        end
    endtask

    // port monitor sampled on the rising edge
    always @(posedge clk) begin
        if (tile_valid_i && tile_ready_o)
            accept_cycle <= cycle;
        if (tile_valid_i && !tile_ready_o)
            stall_seen = 1'b1;
        if (y_valid_o && y_ready_i)
            take_y();
        cycle <= cycle + 1;
    end

    // watchdog
    always @(posedge clk) begin
        if (cycle >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, an output is missing or stuck", cycle);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ==============================================
    // stimulus helpers entered on a falling edge
    // ==============================================
    task automatic fill_random();
        cur_delta = rand_data();
        cur_da    = rand_data();
        cur_d     = rand_data();
        for (int p = 0; p < P; p++) begin
            cur_x[p] = rand_data();
            for (int n = 0; n < N; n++)
                cur_h[p][n] = rand_data();
        end
        for (int n = 0; n < N; n++) begin
            cur_b[n] = rand_data();
            cur_c[n] = rand_data();
        end
    endtask

    // hold the tile until accepted and return on the next falling edge
    task automatic drive_tile();
        delta_i = cur_delta;
        da_i    = cur_da;
        d_i     = cur_d;
        for (int p = 0; p < P; p++) begin
            x_i[p*DW +: DW] = cur_x[p];
            for (int n = 0; n < N; n++)
                hprev_i[(p*N+n)*DW +: DW] = cur_h[p][n];
        end
        for (int n = 0; n < N; n++) begin
            b_i[n*DW +: DW] = cur_b[n];
            c_i[n*DW +: DW] = cur_c[n];
        end
        tile_valid_i = 1'b1;
        do
            @(posedge clk);
        while (!tile_ready_o);
        @(negedge clk);
    endtask

    task automatic send_groups(input int groups);
        for (int t = 0; t < groups * TPG; t++) begin
            fill_random();
            model_tile();
            drive_tile();
        end
        tile_valid_i = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0)
            @(negedge clk);
        // a little slack to catch stray outputs
        repeat (3) @(negedge clk);
    endtask

    task automatic end_test(input string name, input int errs0);
        tests_run++;
        if (err_cnt != errs0)
            tests_failed++;
        $display("test %0d %s: %0d errors", tests_run, name, err_cnt - errs0);
    endtask

    // ==============================================
    // tests
    // ==============================================
    task automatic test_known_values();
        int errs0;
        int y0;
        errs0     = err_cnt;
        y0        = y_count;
        cur_delta = 16'sd256;
        cur_da    = 16'sd256;
        cur_d     = 16'sd256;
        cur_x[0]  = 16'sd256;
        cur_x[1]  = 16'sd512;
        for (int n = 0; n < N; n++) begin
            cur_b[n] = 16'sd256;
            cur_c[n] = 16'sd256;
            for (int p = 0; p < P; p++)
                cur_h[p][n] = '0;
        end
        // y = 4x + 4(1+x) + x = 9x+4 which gives 13.0 and 22.0 in Q8.8
        exp_q.push_back({24'sd5632, 24'sd3328});
        drive_tile();
        // second tile starts from hprev = 1.0
        for (int p = 0; p < P; p++)
            for (int n = 0; n < N; n++)
                cur_h[p][n] = 16'sd256;
        drive_tile();
        tile_valid_i = 1'b0;
        wait_drain();
        check_count("known values", 1, y_count - y0);
        end_test("known values", errs0);
    endtask

    task automatic test_streaming();
        int errs0;
        int y0;
        errs0 = err_cnt;
        y0    = y_count;
        send_groups(20);
        wait_drain();
        check_count("streaming", 20, y_count - y0);
        end_test("streaming", errs0);
    endtask

    task automatic test_latency();
        int errs0;
        errs0 = err_cnt;
        send_groups(1);
        do
            @(posedge clk);
        while (!y_valid_o);
        check_latency(4, cycle - accept_cycle);
        @(negedge clk);
        wait_drain();
        end_test("fixed latency", errs0);
    endtask

    task automatic test_backpressure();
        int errs0;
        int y0;
        errs0       = err_cnt;
        y0          = y_count;
        // long first stall so the whole pipeline fills
        stretch[0]  = 12;
        for (int i = 1; i < 16; i++)
            stretch[i] = ($random(seed) & 15) + 1;
        stall_seen  = 1'b0;
        stream_done = 1'b0;
        fork
            begin
                send_groups(8);
                stream_done = 1'b1;
            end
            begin
                for (int i = 0; i < 16; i++) begin
                    if (!stream_done) begin
                        y_ready_i = 1'b0;
                        repeat (stretch[i]) @(negedge clk);
                        y_ready_i = 1'b1;
                        repeat (2) @(negedge clk);
                    end
                end
            end
        join
        y_ready_i = 1'b1;
        wait_drain();
        if (!stall_seen) begin
            $display("tile_ready_o never fell while y_o was held");
            err_cnt++;
        end
        check_count("back-pressure", 8, y_count - y0);
        end_test("back-pressure", errs0);
    endtask

    task automatic test_reset_mid_group();
        int errs0;
        int y0;
        errs0     = err_cnt;
        // leave one finished group pending so the reset has a y to drop
        y_ready_i = 1'b0;
        send_groups(1);
        // the aborted tile never enters the model
        fill_random();
        drive_tile();
        tile_valid_i = 1'b0;
        repeat (5) @(negedge clk);
        if (y_valid_o !== 1'b1) begin
            $display("y_valid_o not pending before the mid-group reset");
            err_cnt++;
        end
        rstn = 1'b0;
        repeat (2) @(negedge clk);
        if (y_valid_o !== 1'b0) begin
            $display("y_valid_o not low during the mid-group reset");
            err_cnt++;
        end
        // the pending y is lost with the reset
        exp_q.delete();
        rstn      = 1'b1;
        y_ready_i = 1'b1;
        model_cnt = 0;
        @(negedge clk);
        y0 = y_count;
        send_groups(1);
        wait_drain();
        check_count("reset mid-group", 1, y_count - y0);
        end_test("reset mid-group", errs0);
    endtask

    initial begin
        rstn         = 1'b0;
        tile_valid_i = 1'b0;
        y_ready_i    = 1'b1;
        delta_i      = '0;
        da_i         = '0;
        d_i          = '0;
        x_i          = '0;
        b_i          = '0;
        c_i          = '0;
        hprev_i      = '0;
        stall_seen   = 1'b0;
        stream_done  = 1'b0;
        repeat (8) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        test_known_values();
        test_streaming();
        test_latency();
        test_backpressure();
        test_reset_mid_group();
        $display("tests %0d, failed %0d, errors %0d, y outputs %0d",
                 tests_run, tests_failed, err_cnt, y_count);
        if (err_cnt == 0 && tests_failed == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire
